// File: project.f
src/fetch_pkg.sv
src/pc_gen.sv
src/icache_array.sv
src/icache_ctrl.sv
src/instr_buf.sv
src/fetch_top.sv
testbench/fetch_asserts.sv
testbench/tb_fetch.sv

// File: testbench/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

    import fetch_pkg::*;

    localparam int TARGET_XFERS = 3000;
    localparam int STALL_LIMIT  = 500;
    localparam int CYCLE_LIMIT  = 200000;

    logic   clk;
    logic   rst;
    logic   redirect_valid_i;
    addr_t  redirect_pc_i;
    logic   instr_ready_i;
    logic   instr_valid_o;
    instr_t instr_o;
    addr_t  instr_pc_o;
    logic   mem_req_ready_i;
    logic   mem_req_valid_o;
    addr_t  mem_addr_o;
    logic   mem_resp_valid_i;
    line_t  mem_resp_data_i;
    logic   mem_resp_ready_o;

    // stimulus and memory responder state
    logic [31:0] rng;
    logic        mem_busy;
    addr_t       resp_addr;
    int          resp_delay;
    // reference model
    addr_t       exp_pc;
    addr_t       look_pc;
    addr_t       prev_look_pc;
    logic        prev_req_valid;
    logic        model_valid [NUM_LINES];
    tag_t        model_tag   [NUM_LINES];
    int          xfers;
    int          stall;
    int          cycles;
    int          error_count;

    fetch_top u_fetch_top (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .instr_ready_i    (instr_ready_i),
        .instr_valid_o    (instr_valid_o),
        .instr_o          (instr_o),
        .instr_pc_o       (instr_pc_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_addr_o       (mem_addr_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_data_i  (mem_resp_data_i),
        .mem_resp_ready_o (mem_resp_ready_o)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory image where every bit of the word address feeds the mix
    function automatic instr_t word_hash(input addr_t a);
        logic [31:0] h;
        h = a[31:0] ^ a[63:32] ^ 32'h3c6e_f372;
        h = h * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        return h ^ (h >> 13);
    endfunction

    // 16-byte lines, so the low offset bits are zero
    function automatic addr_t line_of(input addr_t a);
        return (a >> OFFSET_W) << OFFSET_W;
    endfunction

    // word 0 in the low bits
    function automatic line_t make_line(input addr_t a);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = word_hash(line_of(a) + addr_t'(4 * w));
        end
        return l;
    endfunction

    task automatic stop_on_error(input string what);
        error_count++;
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    // falling edge drive of decode ready, redirect and memory side
    task automatic drive_inputs();
        rng = xorshift(rng);
        instr_ready_i = (rng % 10) < 7;
        rng = xorshift(rng);
        mem_req_ready_i = rng[3];
        rng = xorshift(rng);
        // no redirect until the reset pc went out
        if (xfers > 0 && (rng % 100) < 5) begin
            rng = xorshift(rng);
            redirect_valid_i = 1'b1;
            redirect_pc_i    = RESET_PC + addr_t'(rng & 32'h7fc);
        end else begin
            redirect_valid_i = 1'b0;
        end
        if (!mem_busy) begin
            mem_resp_valid_i = 1'b0;
        end else if (!mem_resp_valid_i) begin
            if (resp_delay == 0) begin
                mem_resp_valid_i = 1'b1;
                mem_resp_data_i  = make_line(resp_addr);
            end else begin
                resp_delay--;
            end
        end
    endtask

    // everything here is the settled state just before the rising edge
    task automatic observe_cycle();
        index_t idx;
        tag_t   tag;
        cycles++;
        // lookup pc sits one word past a held entry
        look_pc = instr_valid_o ? exp_pc + addr_t'(4) : exp_pc;
        // response ready only while a refill is in flight
        assert (mem_resp_ready_o == mem_busy) else begin
            stop_on_error($sformatf("FAILED %0t mem_resp_ready_o got %b expected %b",
                $time, mem_resp_ready_o, mem_busy));
        end
        // a new request belongs to last cycle's miss
        if (mem_req_valid_o && !prev_req_valid) begin
            idx = prev_look_pc[OFFSET_W +: INDEX_W];
            tag = prev_look_pc[OFFSET_W + INDEX_W +: TAG_W];
            assert (mem_addr_o == line_of(prev_look_pc)) else begin
                stop_on_error($sformatf("FAILED %0t mem_addr_o got %h expected %h",
                    $time, mem_addr_o, line_of(prev_look_pc)));
            end
            assert (!(model_valid[idx] && model_tag[idx] == tag)) else begin
                stop_on_error($sformatf("memory request at %0t for cached line %h",
                    $time, mem_addr_o));
            end
        end
        if (instr_valid_o && instr_ready_i) begin
            assert (instr_pc_o == exp_pc) else begin
                stop_on_error($sformatf("FAILED %0t instr_pc_o got %h expected %h",
                    $time, instr_pc_o, exp_pc));
            end
            assert (instr_o == word_hash(exp_pc)) else begin
                stop_on_error($sformatf("FAILED %0t instr_o got %h expected %h",
                    $time, instr_o, word_hash(exp_pc)));
            end
            exp_pc = exp_pc + addr_t'(4);
            xfers++;
            stall = 0;
        end else begin
            stall++;
        end
        // transfer above still counted for the old stream
        if (redirect_valid_i) begin
            exp_pc = redirect_pc_i;
        end
        if (mem_req_valid_o && mem_req_ready_i) begin
            assert (!mem_busy) else begin
                stop_on_error("a second memory request was accepted during a refill");
            end
            mem_busy   = 1'b1;
            resp_addr  = mem_addr_o;
            rng        = xorshift(rng);
            resp_delay = rng % 6;
        end
        if (mem_resp_valid_i && mem_resp_ready_o) begin
            idx = resp_addr[OFFSET_W +: INDEX_W];
            model_valid[idx] = 1'b1;
            model_tag[idx]   = resp_addr[OFFSET_W + INDEX_W +: TAG_W];
            mem_busy         = 1'b0;
        end
        prev_look_pc   = look_pc;
        prev_req_valid = mem_req_valid_o;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rng              = 32'h1d87;
        rst              = 1'b1;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        instr_ready_i    = 1'b0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_data_i  = '0;
        mem_busy         = 1'b0;
        resp_addr        = '0;
        resp_delay       = 0;
        exp_pc           = RESET_PC;
        prev_look_pc     = RESET_PC;
        prev_req_valid   = 1'b0;
        xfers            = 0;
        stall            = 0;
        cycles           = 0;
        error_count      = 0;
        for (int i = 0; i < NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        // two rising edges in reset
        repeat (2) @(negedge clk);
        rst = 1'b0;
        while (xfers < TARGET_XFERS) begin
            drive_inputs();
            #1;
            observe_cycle();
            assert (u_fetch_top.u_fetch_asserts.fail_count == 0) else begin
                stop_on_error("a bound handshake assertion failed");
            end
            if (stall > STALL_LIMIT) begin
                stop_on_error("timeout, decode saw no instruction for too many cycles");
            end
            if (cycles > CYCLE_LIMIT) begin
                stop_on_error("timeout, run exceeded its cycle limit");
            end
            @(negedge clk);
        end
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: testbench/fetch_asserts.sv
`timescale 1ns/1ps

module fetch_asserts (
    input logic              clk,
    input logic              rst,
    input logic              redirect_valid_i,
    input logic              instr_ready_i,
    input logic              instr_valid_i,
    input fetch_pkg::instr_t instr_i,
    input fetch_pkg::addr_t  instr_pc_i,
    input logic              mem_req_ready_i,
    input logic              mem_req_valid_i,
    input fetch_pkg::addr_t  mem_addr_i,
    input logic              mem_resp_ready_i
);

    // number of failed handshake checks
    int fail_count = 0;

    // decode entry holds under back-pressure unless a redirect drops it
    a_instr_hold: assert property (@(posedge clk) disable iff (rst)
        instr_valid_i && !instr_ready_i && !redirect_valid_i
        |=> instr_valid_i && $stable(instr_i) && $stable(instr_pc_i))
        else begin
            $error("decode valid or payload changed under back-pressure");
            fail_count++;
        end

    // line request stays up with the same address until memory takes it
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_i && !mem_req_ready_i
        |=> mem_req_valid_i && $stable(mem_addr_i))
        else begin
            $error("memory request dropped or changed before the handshake");
            fail_count++;
        end

    // all three handshake outputs quiet right after reset
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !instr_valid_i && !mem_req_valid_i && !mem_resp_ready_i)
        else begin
            $error("handshake output high in the cycle after reset");
            fail_count++;
        end

endmodule

bind fetch_top fetch_asserts u_fetch_asserts (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .instr_ready_i    (instr_ready_i),
    .instr_valid_i    (instr_valid_o),
    .instr_i          (instr_o),
    .instr_pc_i       (instr_pc_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_req_valid_i  (mem_req_valid_o),
    .mem_addr_i       (mem_addr_o),
    .mem_resp_ready_i (mem_resp_ready_o)
);

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic              clk,
    input  logic              rst,
    // redirect from the core
    input  logic              redirect_valid_i,
    input  fetch_pkg::addr_t  redirect_pc_i,
    // decode handshake
    input  logic              instr_ready_i,
    output logic              instr_valid_o,
    output fetch_pkg::instr_t instr_o,
    output fetch_pkg::addr_t  instr_pc_o,
    // memory request
    input  logic              mem_req_ready_i,
    output logic              mem_req_valid_o,
    output fetch_pkg::addr_t  mem_addr_o,
    // memory response, one full line
    input  logic              mem_resp_valid_i,
    input  fetch_pkg::line_t  mem_resp_data_i,
    output logic              mem_resp_ready_o
);

    import fetch_pkg::*;

    addr_t  pc;
    logic   pc_advance;
    logic   hit;
    instr_t hit_word;
    logic   fill_en;
    addr_t  fill_pc;
    line_t  fill_line;
    logic   buf_load;
    logic   buf_free;

    pc_gen u_pc_gen (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .advance_i        (pc_advance),
        .pc_o             (pc)
    );

    icache_array u_icache_array (
        .clk         (clk),
        .rst         (rst),
        .pc_i        (pc),
        .fill_en_i   (fill_en),
        .fill_pc_i   (fill_pc),
        .fill_line_i (fill_line),
        .hit_o       (hit),
        .word_o      (hit_word)
    );

    icache_ctrl u_icache_ctrl (
        .clk              (clk),
        .rst              (rst),
        .pc_i             (pc),
        .redirect_valid_i (redirect_valid_i),
        .hit_i            (hit),
        .buf_free_i       (buf_free),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_data_i  (mem_resp_data_i),
        .buf_load_o       (buf_load),
        .pc_advance_o     (pc_advance),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_addr_o       (mem_addr_o),
        .mem_resp_ready_o (mem_resp_ready_o),
        .fill_en_o        (fill_en),
        .fill_pc_o        (fill_pc),
        .fill_line_o      (fill_line)
    );

    // a redirect flushes the held instruction
    instr_buf u_instr_buf (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (redirect_valid_i),
        .load_i        (buf_load),
        .instr_i       (hit_word),
        .pc_i          (pc),
        .instr_ready_i (instr_ready_i),
        .free_o        (buf_free),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o)
    );

endmodule

// File: src/instr_buf.sv
`timescale 1ns/1ps

module instr_buf (
    input  logic              clk,
    input  logic              rst,
    // redirect drops whatever is held
    input  logic              flush_i,
    input  logic              load_i,
    input  fetch_pkg::instr_t instr_i,
    input  fetch_pkg::addr_t  pc_i,
    input  logic              instr_ready_i,
    output logic              free_o,
    output logic              instr_valid_o,
    output fetch_pkg::instr_t instr_o,
    output fetch_pkg::addr_t  instr_pc_o
);

    import fetch_pkg::*;

    logic   valid_q;
    instr_t instr_q;
    addr_t  pc_q;

    // empty, or the held entry leaves on this edge
    assign free_o = !valid_q || instr_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            // a transfer on this edge still completes for the old stream
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (instr_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // payload only moves on a load, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (load_i) begin
            instr_q <= instr_i;
            pc_q    <= pc_i;
        end
    end

    assign instr_valid_o = valid_q;
    assign instr_o       = instr_q;
    assign instr_pc_o    = pc_q;

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  fetch_pkg::addr_t  pc_i,
    input  logic              redirect_valid_i,
    // lookup result and buffer space
    input  logic              hit_i,
    input  logic              buf_free_i,
    // memory request handshake
    input  logic              mem_req_ready_i,
    // memory response handshake
    input  logic              mem_resp_valid_i,
    input  fetch_pkg::line_t  mem_resp_data_i,
    output logic              buf_load_o,
    output logic              pc_advance_o,
    output logic              mem_req_valid_o,
    output fetch_pkg::addr_t  mem_addr_o,
    output logic              mem_resp_ready_o,
    output logic              fill_en_o,
    output fetch_pkg::addr_t  fill_pc_o,
    output fetch_pkg::line_t  fill_line_o
);

    import fetch_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // line address of the outstanding miss
    addr_t miss_addr_q;
    addr_t pc_line;
    logic  resp_hs;

    // clear the byte offset within a line
    assign pc_line = pc_i & ~addr_t'(LINE_BYTES - 1);

    assign resp_hs = mem_resp_valid_i && mem_resp_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_LOOKUP: begin
                // a miss under a redirect is not for the new pc, skip it
                if (!hit_i && !redirect_valid_i) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ: begin
                // request stays up until taken, even across a redirect
                if (mem_req_ready_i) begin
                    state_d = redirect_valid_i ? ST_DROP : ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (resp_hs) begin
                    state_d = ST_LOOKUP;
                end else if (redirect_valid_i) begin
                    state_d = ST_DROP;
                end
            end
            ST_DROP: begin
                // line is still good for its own address, fill and move on
                if (resp_hs) begin
                    state_d = ST_LOOKUP;
                end
            end
            default: state_d = ST_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    // capture the line on the miss edge
    always_ff @(posedge clk) begin
        if (state_q == ST_LOOKUP && state_d == ST_REQ) begin
            miss_addr_q <= pc_line;
        end
    end

    // deliver only on a hit with room, never in a redirect cycle
    assign buf_load_o   = (state_q == ST_LOOKUP) && hit_i && buf_free_i && !redirect_valid_i;
    assign pc_advance_o = buf_load_o;

    assign mem_req_valid_o  = (state_q == ST_REQ);
    assign mem_addr_o       = miss_addr_q;
    assign mem_resp_ready_o = (state_q == ST_WAIT) || (state_q == ST_DROP);

    // response goes straight into the array on the handshake edge
    assign fill_en_o   = resp_hs;
    assign fill_pc_o   = miss_addr_q;
    assign fill_line_o = mem_resp_data_i;

endmodule

// File: src/icache_array.sv
`timescale 1ns/1ps

module icache_array (
    input  logic              clk,
    input  logic              rst,
    // lookup side
    input  fetch_pkg::addr_t  pc_i,
    // refill side
    input  logic              fill_en_i,
    input  fetch_pkg::addr_t  fill_pc_i,
    input  fetch_pkg::line_t  fill_line_i,
    output logic              hit_o,
    output fetch_pkg::instr_t word_o
);

    import fetch_pkg::*;

    // one valid bit per line, the only state that needs reset
    logic [NUM_LINES-1:0] valid_q;
    tag_t                 tag_q  [NUM_LINES];
    line_t                data_q [NUM_LINES];

    index_t     rd_idx;
    tag_t       rd_tag;
    logic [1:0] word_sel;
    line_t      rd_line;
    index_t     wr_idx;

    // split the lookup pc into tag, index and word
    assign rd_idx   = pc_i[OFFSET_W +: INDEX_W];
    assign rd_tag   = pc_i[OFFSET_W + INDEX_W +: TAG_W];
    assign word_sel = pc_i[3:2];

    // fill address selects the line to overwrite
    assign wr_idx = fill_pc_i[OFFSET_W +: INDEX_W];

    // combinational compare on the registered arrays
    assign rd_line = data_q[rd_idx];
    assign hit_o   = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // four words per line, pc bits 3:2 pick one
    assign word_o = rd_line[word_sel * 32 +: 32];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and data only change on a refill
    always_ff @(posedge clk) begin
        if (fill_en_i) begin
            tag_q[wr_idx]  <= fill_pc_i[OFFSET_W + INDEX_W +: TAG_W];
            data_q[wr_idx] <= fill_line_i;
        end
    end

endmodule

// File: src/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic              clk,
    input  logic              rst,
    // redirect from the core, one cycle pulse
    input  logic              redirect_valid_i,
    input  fetch_pkg::addr_t  redirect_pc_i,
    // current pc was handed to the output buffer
    input  logic              advance_i,
    output fetch_pkg::addr_t  pc_o
);

    import fetch_pkg::*;

    addr_t pc_q;
    addr_t pc_seq;

    // next sequential fetch, no compressed instructions
    assign pc_seq = pc_q + addr_t'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid_i) begin
            // redirect wins over a delivery in the same cycle,
            // that instruction is flushed anyway
            pc_q <= redirect_pc_i;
        end else if (advance_i) begin
            pc_q <= pc_seq;
        end
    end

    // pc being looked up this cycle
    assign pc_o = pc_q;

endmodule

// File: src/fetch_pkg.sv
package fetch_pkg;

    // byte address or pc value
    typedef logic [63:0] addr_t;
    // one 32-bit instruction word
    typedef logic [31:0] instr_t;
    // one cache line, same width as the memory response
    typedef logic [127:0] line_t;

    // cache geometry, direct mapped
    localparam int LINE_BYTES = 16;
    localparam int NUM_LINES  = 16;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = 56;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // first fetch address out of reset
    localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

    // cache controller states
    // lookup: compare and deliver on hit
    // req: line request held until memory takes it
    // wait: refill in flight for the current pc
    // drop: refill in flight but a redirect made it stale
    typedef enum logic [1:0] {
        ST_LOOKUP,
        ST_REQ,
        ST_WAIT,
        ST_DROP
    } ctrl_state_t;

endpackage
